/* src/tuvv_pkg.sv */
`default_nettype none

package tuvv_pkg;

	localparam int ADDR_W   = 20;
	localparam int DATA_W   = 32;
	localparam int GROUP_W  = 32;	// switches per group
	localparam int N_GROUPS = 4;	// groups a, b, c, d
	localparam int N_CHAN   = 4;

	// register offsets, matched against addr[19:4]
	localparam logic [15:0] OFS_IN_1   = 16'h1300;
	localparam logic [15:0] OFS_IN_2   = 16'h1310;
	localparam logic [15:0] OFS_SENS   = 16'h1320;
	localparam logic [15:0] OFS_R_ERR  = 16'hF000;
	localparam logic [15:0] OFS_R_TEST = 16'hFFF0;

	typedef enum logic [3:0]
	{
		MODE_FULL    = 4'h1,
		MODE_GROUP   = 4'h2,
		MODE_ADDR    = 4'h4,
		MODE_SECTION = 4'h8
	} cmd_mode_e;

	typedef enum logic [2:0]
	{
		GRP_A = 3'd1,
		GRP_B = 3'd2,
		GRP_C = 3'd3,
		GRP_D = 3'd4
	} group_e;

	typedef enum logic [1:0]
	{
		CH_OFF      = 2'd0,
		CH_ANALOG   = 2'd1,
		CH_PARAM    = 2'd2,
		CH_DISCRETE = 2'd3
	} chan_mode_e;

	typedef struct packed
	{
		logic [2:0] spare_hi;
		logic [4:0] index;	// switch number within a group
		logic       enable;
		group_e     group;
		logic [2:0] spare;
		logic       on;	// 1 closes, 0 opens
		cmd_mode_e  mode;
	} cmd_word_t;

	typedef struct packed
	{
		logic [N_GROUPS-1:0][GROUP_W-1:0] sel;	// sensor select
		logic [N_GROUPS-1:0][GROUP_W-1:0] sus;	// substitute
	} matrix_t;

	typedef struct packed
	{
		logic [N_CHAN-1:0] set_v;	// analog
		logic [N_CHAN-1:0] set_r;	// parametric
		logic [N_CHAN-1:0] set_gnd;	// discrete
	} sens_out_t;

	typedef struct packed
	{
		logic              in_1;
		logic              in_2;
		logic              sens;
		logic [DATA_W-1:0] data;
	} bus_wr_t;

endpackage

`default_nettype wire

/* src/host_port.sv */
`default_nettype none

module host_port
(
	input  logic                         clk,
	input  logic                         rst_,
	input  logic                         valid,
	input  logic                         a_d,
	input  logic                         rd_wr,
	input  logic [tuvv_pkg::ADDR_W-1:0]  addr,
	input  logic [tuvv_pkg::DATA_W-1:0]  wdata,
	input  tuvv_pkg::cmd_word_t          in_1,
	input  tuvv_pkg::cmd_word_t          in_2,
	input  logic [7:0]                   sens_raw,
	input  logic                         busy,
	output tuvv_pkg::bus_wr_t            wr,
	output logic [tuvv_pkg::DATA_W-1:0]  rdata,
	output logic                         rd_valid
);

	import tuvv_pkg::*;

	logic [15:0] ofs;
	logic addr_ph;
	logic data_wr;
	logic sel_in_1;
	logic sel_in_2;
	logic sel_sens;
	logic sel_err;
	logic sel_test;
	logic known;
	logic bad_mode;
	logic err_check;	// R_ERR was addressed, clear on next phase
	logic [7:0] r_err;
	logic [DATA_W-1:0] r_test;
	cmd_word_t wcmd;

	assign ofs     = addr[19:4];
	assign addr_ph = valid & a_d;
	assign data_wr = valid & ~a_d & rd_wr;

	assign sel_in_1 = (ofs == OFS_IN_1);
	assign sel_in_2 = (ofs == OFS_IN_2);
	assign sel_sens = (ofs == OFS_SENS);
	assign sel_err  = (ofs == OFS_R_ERR);
	assign sel_test = (ofs == OFS_R_TEST);
	assign known    = sel_in_1 | sel_in_2 | sel_sens | sel_err | sel_test;

	assign wr.in_1 = data_wr & sel_in_1;
	assign wr.in_2 = data_wr & sel_in_2;
	assign wr.sens = data_wr & sel_sens;
	assign wr.data = wdata;

	// mode check on the incoming command word
	assign wcmd     = cmd_word_t'(wdata[19:0]);
	assign bad_mode = (wr.in_1 | wr.in_2) &&
		!(wcmd.mode inside {MODE_FULL, MODE_GROUP, MODE_ADDR, MODE_SECTION});

	always_ff @(posedge clk)
	begin
		if (!rst_)
		begin
			rd_valid  <= 1'b0;
			r_err     <= '0;
			err_check <= 1'b0;
			r_test    <= '0;
		end
		else
		begin
			rd_valid <= addr_ph & ~rd_wr;
			if (addr_ph)
			begin
				if (!known)
					r_err[0] <= 1'b1;	// bad address, pending clear stays armed
				else
				begin
					if (err_check)
						r_err <= '0;
					err_check <= sel_err;
				end
			end
			if (bad_mode)
				r_err[7] <= 1'b1;
			if (data_wr && sel_test)
				r_test <= wdata;
		end
	end

	// readback, zero for writes and unknown offsets
	always_comb
	begin
		rdata = '0;
		if (!rd_wr)
		begin
			case (ofs)
				OFS_IN_1:   rdata = {14'b0, busy, in_1[16:0]};
				OFS_IN_2:   rdata = {12'b0, in_2};
				OFS_SENS:   rdata = {24'b0, sens_raw};
				OFS_R_ERR:  rdata = {24'b0, r_err};
				OFS_R_TEST: rdata = r_test;
				default:    rdata = '0;
			endcase
		end
	end

endmodule

`default_nettype wire

/* src/matrix_ctrl.sv */
`default_nettype none

module matrix_ctrl
#(
	parameter int GROUP_W = tuvv_pkg::GROUP_W
)
(
	input  logic                clk,
	input  logic                rst_,
	input  tuvv_pkg::bus_wr_t   wr,
	output tuvv_pkg::matrix_t   matrix,
	output tuvv_pkg::cmd_word_t in_1,
	output tuvv_pkg::cmd_word_t in_2
);

	import tuvv_pkg::*;

	logic apply_1;	// IN_1 written last cycle
	logic apply_2;
	matrix_t next_m;

	// one command applied to the matrix; target is sus when to_sus is set
	function automatic matrix_t apply_cmd(matrix_t m, cmd_word_t c, logic to_sus);
		logic [N_GROUPS-1:0][GROUP_W-1:0] tgt;
		logic [N_GROUPS-1:0][GROUP_W-1:0] oth;
		logic [N_GROUPS-1:0][GROUP_W-1:0] hit;
		logic [GROUP_W-1:0] bit_mask;
		logic grp_ok;
		logic [1:0] gi;
		tgt = to_sus ? m.sus : m.sel;
		oth = to_sus ? m.sel : m.sus;
		bit_mask = '0;
		if (c.index < GROUP_W)
			bit_mask[c.index] = 1'b1;	// out of range index hits nothing
		grp_ok = c.group inside {GRP_A, GRP_B, GRP_C, GRP_D};
		gi = 2'(c.group - 3'd1);
		hit = '0;
		case (c.mode)
			MODE_FULL:
				hit = '1;
			MODE_GROUP:
				if (grp_ok)
					hit[gi] = '1;
			MODE_ADDR:
				if (grp_ok)
					hit[gi] = bit_mask;
			MODE_SECTION:
				for (int g = 0; g < N_GROUPS; g++)
					hit[g] = bit_mask;
			default:
				hit = '0;	// bad mode, flagged in R_ERR
		endcase
		if (c.on)
		begin
			tgt = tgt | hit;
			oth = oth & ~hit;	// never sel and sus together
		end
		else
			tgt = tgt & ~hit;
		m.sel = to_sus ? oth : tgt;
		m.sus = to_sus ? tgt : oth;
		return m;
	endfunction

	always_comb
	begin
		next_m = matrix;
		if (apply_1)
			next_m = apply_cmd(next_m, in_1, 1'b0);
		if (apply_2)
			next_m = apply_cmd(next_m, in_2, 1'b1);
	end

	always_ff @(posedge clk)
	begin
		if (!rst_)
		begin
			in_1    <= '0;
			in_2    <= '0;
			apply_1 <= 1'b0;
			apply_2 <= 1'b0;
			matrix  <= '0;
		end
		else
		begin
			apply_1 <= wr.in_1;
			apply_2 <= wr.in_2;
			if (wr.in_1)
				in_1 <= cmd_word_t'(wr.data[19:0]);
			if (wr.in_2)
				in_2 <= cmd_word_t'(wr.data[19:0]);
			// both enables low opens everything
			if (!in_1.enable && !in_2.enable)
				matrix <= '0;
			else
				matrix <= next_m;
		end
	end

endmodule

`default_nettype wire

/* src/settle_timer.sv */
`default_nettype none

module settle_timer
#(
	parameter int SETTLE_CYCLES = 50
)
(
	input  logic              clk,
	input  logic              rst_,
	input  tuvv_pkg::matrix_t matrix,
	output logic              busy
);

	localparam int CNT_W = $clog2(SETTLE_CYCLES + 1);

	logic any_closed;
	logic [CNT_W-1:0] cnt;

	assign any_closed = |matrix;

	always_ff @(posedge clk)
	begin
		if (!rst_)
			cnt <= '0;
		else if (any_closed)
			cnt <= CNT_W'(SETTLE_CYCLES);	// hold full while closed
		else if (cnt != '0)
			cnt <= cnt - 1'b1;	// settling after open
	end

	assign busy = (cnt != '0);

endmodule

`default_nettype wire

/* src/sens_ctrl.sv */
`default_nettype none

module sens_ctrl
(
	input  logic                clk,
	input  logic                rst_,
	input  tuvv_pkg::bus_wr_t   wr,
	output tuvv_pkg::sens_out_t sens,
	output logic [7:0]          sens_raw
);

	import tuvv_pkg::*;

	logic [2*N_CHAN-1:0] pend;
	logic [2*N_CHAN-1:0] active;
	logic move;	// pending value waits one cycle

	// break before make: outputs drop for a cycle on every write
	always_ff @(posedge clk)
	begin
		if (!rst_)
		begin
			pend   <= '0;
			active <= '0;
			move   <= 1'b0;
		end
		else if (wr.sens)
		begin
			pend   <= wr.data[2*N_CHAN-1:0];
			active <= '0;
			move   <= 1'b1;
		end
		else if (move)
		begin
			active <= pend;
			move   <= 1'b0;
		end
	end

	always_comb
	begin
		sens = '0;
		for (int ch = 0; ch < N_CHAN; ch++)
		begin
			case (chan_mode_e'(active[2*ch +: 2]))
				CH_ANALOG:   sens.set_v[ch]   = 1'b1;
				CH_PARAM:    sens.set_r[ch]   = 1'b1;
				CH_DISCRETE: sens.set_gnd[ch] = 1'b1;
				default:     ;	// channel off
			endcase
		end
	end

	assign sens_raw = active;

endmodule

`default_nettype wire

/* src/tuvv_ctrl.sv */
`default_nettype none

module tuvv_ctrl
#(
	parameter int GROUP_W       = tuvv_pkg::GROUP_W,
	parameter int SETTLE_CYCLES = 50
)
(
	input  logic                         clk,
	input  logic                         rst_,
	input  logic                         valid,
	input  logic                         a_d,	// 1 address, 0 data
	input  logic                         rd_wr,	// 1 write
	input  logic [tuvv_pkg::ADDR_W-1:0]  addr,
	input  logic [tuvv_pkg::DATA_W-1:0]  wdata,
	output logic [tuvv_pkg::DATA_W-1:0]  rdata,
	output logic                         rd_valid,
	output tuvv_pkg::matrix_t            matrix,
	output tuvv_pkg::sens_out_t          sens,
	output logic                         busy
);

	import tuvv_pkg::*;

	bus_wr_t wr;
	cmd_word_t in_1;
	cmd_word_t in_2;
	logic [7:0] sens_raw;

	host_port u_host_port
	(
		.clk      (clk),
		.rst_     (rst_),
		.valid    (valid),
		.a_d      (a_d),
		.rd_wr    (rd_wr),
		.addr     (addr),
		.wdata    (wdata),
		.in_1     (in_1),
		.in_2     (in_2),
		.sens_raw (sens_raw),
		.busy     (busy),
		.wr       (wr),
		.rdata    (rdata),
		.rd_valid (rd_valid)
	);

	matrix_ctrl #(.GROUP_W(GROUP_W)) u_matrix_ctrl
	(
		.clk    (clk),
		.rst_   (rst_),
		.wr     (wr),
		.matrix (matrix),
		.in_1   (in_1),
		.in_2   (in_2)
	);

	settle_timer #(.SETTLE_CYCLES(SETTLE_CYCLES)) u_settle_timer
	(
		.clk    (clk),
		.rst_   (rst_),
		.matrix (matrix),
		.busy   (busy)
	);

	sens_ctrl u_sens_ctrl
	(
		.clk      (clk),
		.rst_     (rst_),
		.wr       (wr),
		.sens     (sens),
		.sens_raw (sens_raw)
	);

endmodule

`default_nettype wire

/* test/tuvv_ctrl_asserts.sv */
`default_nettype none

module tuvv_ctrl_asserts
(
	input logic                clk,
	input logic                rst_,
	input tuvv_pkg::matrix_t   matrix,
	input tuvv_pkg::sens_out_t sens,
	input tuvv_pkg::bus_wr_t   wr,
	input logic                busy
);

	timeunit 1ns;
	timeprecision 100ps;

	a_no_double: assert property (@(posedge clk) disable iff (!rst_)
		(matrix.sel & matrix.sus) == '0)
	else $error("a switch is closed in both sel and sus");

	a_one_select: assert property (@(posedge clk) disable iff (!rst_)
		((sens.set_v & sens.set_r) | (sens.set_v & sens.set_gnd)
			| (sens.set_r & sens.set_gnd)) == '0)
	else $error("a sensor channel has more than one select");

	// busy follows a closed switch one edge later
	a_busy_closed: assert property (@(posedge clk) disable iff (!rst_)
		(|matrix) |=> busy)
	else $error("switch closed while busy is low");

	a_sens_break: assert property (@(posedge clk) disable iff (!rst_)
		wr.sens |=> (sens == '0))
	else $error("sens selects not dropped after a SENS write");

endmodule

bind tuvv_ctrl tuvv_ctrl_asserts u_asserts
(
	.clk    (clk),
	.rst_   (rst_),
	.matrix (matrix),
	.sens   (sens),
	.wr     (wr),
	.busy   (busy)
);

`default_nettype wire

/* test/tb_tuvv_ctrl.sv */
`default_nettype none

module tb_tuvv_ctrl;

	timeunit 1ns;
	timeprecision 100ps;

	import tuvv_pkg::*;

	localparam int SETTLE_CYCLES = 50;
	localparam int N_CMDS = 200;
	localparam int N_SENS = 20;
	localparam int N_TEST = 10;
	localparam int N_OPS = N_CMDS + 2 * N_SENS + 2 * N_TEST + 16;
	localparam int LIMIT_NS = (N_OPS * 20 + 2 * SETTLE_CYCLES) * 8;

	logic clk;
	logic rst_;
	logic valid;
	logic a_d;
	logic rd_wr;
	logic [ADDR_W-1:0] addr;
	logic [DATA_W-1:0] wdata;
	logic [DATA_W-1:0] rdata;
	logic rd_valid;
	matrix_t matrix;
	sens_out_t sens;
	logic busy;

	matrix_t exp_m;	// model of the switch state
	logic en_1;	// model enable bits
	logic en_2;
	logic [19:0] cmd_1;	// last IN_1 word
	logic [19:0] cmd_2;	// last IN_2 word
	bit failed;
	bit done;
	int n;
	logic [31:0] v;

	tuvv_ctrl #(.GROUP_W(GROUP_W), .SETTLE_CYCLES(SETTLE_CYCLES)) u_tuvv_ctrl
	(
		.clk      (clk),
		.rst_     (rst_),
		.valid    (valid),
		.a_d      (a_d),
		.rd_wr    (rd_wr),
		.addr     (addr),
		.wdata    (wdata),
		.rdata    (rdata),
		.rd_valid (rd_valid),
		.matrix   (matrix),
		.sens     (sens),
		.busy     (busy)
	);

	initial
	begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	initial
	begin
		#(LIMIT_NS);
		failed = 1'b1;
		$display("watchdog expired at %0t, the DUT stopped responding", $time);
		$display("Simulation finished: FAIL");
		$fatal(1, "timeout");
	end

	task automatic check_value(input string name, input logic [255:0] got,
		input logic [255:0] exp);
		assert (got === exp)
		else
		begin
			failed = 1'b1;
			$display("[FAIL] %0t %s got %0h expected %0h", $time, name, got, exp);
			$display("Simulation finished: FAIL");
			$fatal(1, "value mismatch");
		end
	endtask

	task automatic addr_phase(input logic [15:0] ofs, input logic is_wr);
		@(negedge clk);
		valid = 1'b1;
		a_d = 1'b1;
		rd_wr = is_wr;
		addr = {ofs, 4'h0};
	endtask

	task automatic bus_write(input logic [15:0] ofs, input logic [31:0] d);
		addr_phase(ofs, 1'b1);
		@(negedge clk);
		a_d = 1'b0;	// data phase
		wdata = d;
		@(negedge clk);
		valid = 1'b0;
	endtask

	task automatic read_check(input string name, input logic [15:0] ofs,
		input logic [31:0] exp);
		addr_phase(ofs, 1'b0);
		@(negedge clk);
		valid = 1'b0;
		check_value("rd_valid", rd_valid, 1);
		check_value(name, rdata, exp);
	endtask

	function automatic logic [19:0] make_cmd(input int idx, input bit en, input int grp,
		input bit on, input logic [3:0] mode);
		return {3'b0, 5'(idx), en, 3'(grp), 3'b0, on, mode};
	endfunction

	function automatic logic [3:0] random_mode();
		int r;
		r = $urandom_range(0, 20);
		if (r == 0)
			return 4'h6;	// not a legal mode
		return 4'(1 << (r % 4));
	endfunction

	function automatic sens_out_t expect_sens(input logic [7:0] raw);
		sens_out_t s;
		s = '0;
		for (int ch = 0; ch < N_CHAN; ch++)
		begin
			case (raw[2*ch +: 2])
				2'd1: s.set_v[ch] = 1'b1;
				2'd2: s.set_r[ch] = 1'b1;
				2'd3: s.set_gnd[ch] = 1'b1;
				default: ;
			endcase
		end
		return s;
	endfunction

	// per-switch model of one command
	task automatic model_cmd(input bit to_sus, input logic [19:0] c);
		int grp;
		int idx;
		bit hit;
		grp = int'(c[10:8]);
		idx = int'(c[16:12]);
		for (int g = 0; g < N_GROUPS; g++)
		begin
			for (int b = 0; b < GROUP_W; b++)
			begin
				case (c[3:0])
					4'h1: hit = 1'b1;
					4'h2: hit = (grp == g + 1);
					4'h4: hit = (grp == g + 1) && (idx == b);
					4'h8: hit = (idx == b);
					default: hit = 1'b0;
				endcase
				if (hit && c[4])
				begin
					exp_m.sel[g][b] = !to_sus;	// target closes, other array opens
					exp_m.sus[g][b] = to_sus;
				end
				else if (hit && to_sus)
					exp_m.sus[g][b] = 1'b0;
				else if (hit)
					exp_m.sel[g][b] = 1'b0;
			end
		end
		if (to_sus)
		begin
			en_2 = c[11];
			cmd_2 = c;
		end
		else
		begin
			en_1 = c[11];
			cmd_1 = c;
		end
		if (!en_1 && !en_2)
			exp_m = '0;
	endtask

	task automatic write_cmd(input bit to_sus, input logic [19:0] c);
		bus_write(to_sus ? OFS_IN_2 : OFS_IN_1, {12'h0, c});
		model_cmd(to_sus, c);
		@(negedge clk);	// matrix follows one edge after the write
		check_value("matrix", matrix, exp_m);
	endtask

	// run ended early by a failing bound assertion
	final
	begin
		if (!done && !failed)
			$display("Simulation finished: FAIL");
	end

	initial
	begin
		void'($urandom(32'h633e0e5e));
		rst_ = 1'b0;
		valid = 1'b0;
		a_d = 1'b0;
		rd_wr = 1'b0;
		addr = '0;
		wdata = '0;
		failed = 1'b0;
		done = 1'b0;
		exp_m = '0;
		en_1 = 1'b0;
		en_2 = 1'b0;
		cmd_1 = '0;
		cmd_2 = '0;
		repeat (3) @(negedge clk);
		rst_ = 1'b1;

		// R_ERR set by a bad address and a bad mode, cleared after a read
		read_check("unknown reg", 16'h0BAD, 32'h0);
		write_cmd(1'b0, make_cmd(0, 1'b0, 1, 1'b1, 4'h3));
		read_check("r_err", OFS_R_ERR, 32'h81);
		read_check("r_test", OFS_R_TEST, 32'h0);
		read_check("r_err", OFS_R_ERR, 32'h0);
		read_check("r_test", OFS_R_TEST, 32'h0);

		for (int i = 0; i < N_TEST; i++)
		begin
			v = $urandom;
			bus_write(OFS_R_TEST, v);
			read_check("r_test", OFS_R_TEST, v);
		end

		for (int i = 0; i < N_CMDS; i++)
			write_cmd(1'($urandom_range(0, 1)),
				make_cmd($urandom_range(0, 31), ($urandom_range(0, 3) != 0),
					$urandom_range(0, 5), 1'($urandom_range(0, 1)), random_mode()));
		read_check("in_2", OFS_IN_2, {12'h0, cmd_2});

		// all sel closed, then both enables dropped
		write_cmd(1'b0, make_cmd(0, 1'b1, 0, 1'b1, 4'h1));
		write_cmd(1'b1, make_cmd(0, 1'b0, 0, 1'b0, 4'h2));
		read_check("in_1 busy", OFS_IN_1, {14'b0, 1'b1, cmd_1[16:0]});
		write_cmd(1'b0, make_cmd(0, 1'b0, 0, 1'b0, 4'h2));
		check_value("busy", busy, 1);
		n = 0;
		while (busy && n < 2 * SETTLE_CYCLES)
		begin
			@(negedge clk);
			n++;
		end
		check_value("settle cycles", n, SETTLE_CYCLES);
		read_check("in_1 idle", OFS_IN_1, {15'b0, cmd_1[16:0]});

		for (int i = 0; i < N_SENS; i++)
		begin
			v = $urandom_range(0, 255);
			bus_write(OFS_SENS, v);
			check_value("sens break", sens, '0);
			@(negedge clk);
			check_value("sens", sens, expect_sens(v[7:0]));
			read_check("sens_raw", OFS_SENS, v);
		end

		if (!failed)
		begin
			done = 1'b1;
			$display("Simulation finished: PASS");
		end
		else
			$display("Simulation finished: FAIL");
		$finish;
	end

endmodule

`default_nettype wire

/* verilog.f */
src/tuvv_pkg.sv
src/host_port.sv
src/matrix_ctrl.sv
src/settle_timer.sv
src/sens_ctrl.sv
src/tuvv_ctrl.sv
test/tuvv_ctrl_asserts.sv
test/tb_tuvv_ctrl.sv

/* run.sh */
#!/bin/sh
cd "$(dirname "$0")" &&
rm -f sim.log &&
verilator --binary --timing --assert -Wno-fatal --timescale 1ns/100ps \
	--top-module tb_tuvv_ctrl -f verilog.f -o sim_tuvv &&
{ ./obj_dir/sim_tuvv > sim.log 2>&1 || true; } &&
grep -q "Simulation finished: PASS" sim.log && echo "run passed" ||
{ echo "run failed, see sim.log"; exit 1; }
